// ==== verilog/rv32i_pkg.sv ====
`default_nettype none

package rv32i_pkg;

    // base opcodes
    localparam logic [6:0] op_reg   = 7'b0110011;
    localparam logic [6:0] op_imm   = 7'b0010011;
    localparam logic [6:0] op_load  = 7'b0000011;
    localparam logic [6:0] op_store = 7'b0100011;
    localparam logic [6:0] op_br    = 7'b1100011;
    localparam logic [6:0] op_lui   = 7'b0110111;
    localparam logic [6:0] op_auipc = 7'b0010111;
    localparam logic [6:0] op_jal   = 7'b1101111;
    localparam logic [6:0] op_jalr  = 7'b1100111;

    // M extension, all under op_reg
    localparam logic [2:0] funct3_mul    = 3'b000;
    localparam logic [2:0] funct3_mulh   = 3'b001;
    localparam logic [2:0] funct3_mulhsu = 3'b010;
    localparam logic [2:0] funct3_mulhu  = 3'b011;
    localparam logic [2:0] funct3_div    = 3'b100;
    localparam logic [2:0] funct3_divu   = 3'b101;
    localparam logic [2:0] funct3_rem    = 3'b110;
    localparam logic [2:0] funct3_remu   = 3'b111;

    localparam logic [6:0] muldiv_funct7 = 7'b0000001;

    // one instruction word, seen as R-format or I-format
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r_view;
        struct packed {
            logic [11:0] imm12;   // overlaps funct7 and rs2
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i_view;
    } rv32_inst_u;

endpackage

`default_nettype wire

// ==== verilog/rename_pkg.sv ====
`default_nettype none

package rename_pkg;

    // target reservation station
    typedef enum logic [1:0] {
        rs_alu = 2'b00,
        rs_mul = 2'b01,
        rs_div = 2'b10
    } rs_sel_e;

    // architectural register file
    localparam int arch_regs     = 32;
    localparam int arch_reg_bits = 5;   // log2 of arch_regs

endpackage

`default_nettype wire

// ==== verilog/free_list.sv ====
`timescale 1ns/1ps
`default_nettype none

module free_list #(
    parameter int PHYS_REG_BITS = 6
) (
    input  wire logic                     clk,
    input  wire logic                     arst_n,
    input  wire logic                     alloc,         // pop, from rename
    input  wire logic                     retire_valid,  // push, from ROB retire
    input  wire logic [PHYS_REG_BITS-1:0] retire_pd,
    output logic      [PHYS_REG_BITS-1:0] free_pd,
    output logic                          fl_empty
);

    localparam int depth    = 1 << PHYS_REG_BITS;
    localparam int num_free = depth - rename_pkg::arch_regs;  // unmapped at reset

    logic [PHYS_REG_BITS-1:0] mem [depth];
    logic [PHYS_REG_BITS-1:0] head;
    logic [PHYS_REG_BITS-1:0] tail;
    logic [PHYS_REG_BITS:0]   count;

    assign free_pd  = mem[head];
    assign fl_empty = (count == '0);

    // reset seeds the unmapped registers in ascending order
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < num_free; i++) begin
                mem[i] <= PHYS_REG_BITS'(rename_pkg::arch_regs + i);
            end
            head  <= '0;
            tail  <= PHYS_REG_BITS'(num_free);
            count <= (PHYS_REG_BITS + 1)'(num_free);
        end else begin
            if (alloc) begin
                head <= head + 1'b1;
            end
            if (retire_valid) begin
                mem[tail] <= retire_pd;
                tail      <= tail + 1'b1;  // wraps with the pointer width
            end
            case ({retire_valid, alloc})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;   // idle, or push and pop together
            endcase
        end
    end

    // rename must see fl_empty before it pops
    a_no_pop_empty: assert property (@(posedge clk) disable iff (!arst_n)
        alloc |-> !fl_empty);

    // more retires than allocations would mean a register freed twice
    a_no_push_full: assert property (@(posedge clk) disable iff (!arst_n)
        retire_valid && !alloc |-> count != (PHYS_REG_BITS + 1)'(depth));

endmodule

`default_nettype wire

// ==== verilog/rat.sv ====
`timescale 1ns/1ps
`default_nettype none

module rat #(
    parameter int PHYS_REG_BITS = 6
) (
    input  wire logic                                  clk,
    input  wire logic                                  arst_n,
    input  wire logic [rename_pkg::arch_reg_bits-1:0]  rs1,
    input  wire logic [rename_pkg::arch_reg_bits-1:0]  rs2,
    input  wire logic [rename_pkg::arch_reg_bits-1:0]  rd,
    input  wire logic                                  rename_we,
    input  wire logic [PHYS_REG_BITS-1:0]              rename_pd,
    input  wire logic                                  wb_valid,
    input  wire logic [PHYS_REG_BITS-1:0]              wb_pd,
    output logic      [PHYS_REG_BITS-1:0]              ps1,
    output logic      [PHYS_REG_BITS-1:0]              ps2,
    output logic      [PHYS_REG_BITS-1:0]              old_pd,
    output logic                                       ps1_ready,
    output logic                                       ps2_ready
);

    localparam int depth = 1 << PHYS_REG_BITS;

    logic [PHYS_REG_BITS-1:0] map_q [rename_pkg::arch_regs];
    logic [depth-1:0]         ready_q;  // one bit per physical register

    // x0 is pinned to physical 0 and always ready
    assign ps1       = (rs1 == '0) ? '0 : map_q[rs1];
    assign ps2       = (rs2 == '0) ? '0 : map_q[rs2];
    assign ps1_ready = (rs1 == '0) || ready_q[ps1];
    assign ps2_ready = (rs2 == '0) || ready_q[ps2];
    assign old_pd    = map_q[rd];  // previous owner, freed when this one retires

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < rename_pkg::arch_regs; i++) begin
                map_q[i] <= PHYS_REG_BITS'(i);  // identity map
            end
            ready_q <= '1;
        end else begin
            if (wb_valid) begin
                ready_q[wb_pd] <= 1'b1;
            end
            // placed after the writeback so a rename of the same register wins
            if (rename_we) begin
                map_q[rd]          <= rename_pd;
                ready_q[rename_pd] <= 1'b0;
            end
        end
    end

    // rename logic filters out x0 destinations before asserting rename_we
    a_no_x0_rename: assert property (@(posedge clk) disable iff (!arst_n)
        rename_we |-> rd != '0);

endmodule

`default_nettype wire

// ==== verilog/rename_dispatch.sv ====
`timescale 1ns/1ps
`default_nettype none

module rename_dispatch #(
    parameter int PHYS_REG_BITS = 6
) (
    input  wire logic                                 clk,
    input  wire logic                                 arst_n,
    input  wire logic [31:0]                          inst,
    input  wire logic                                 iq_empty,
    input  wire logic                                 rob_full,
    input  wire logic                                 rs_full_alu,
    input  wire logic                                 rs_full_mul,
    input  wire logic                                 rs_full_div,
    input  wire logic [PHYS_REG_BITS-1:0]             rob_tag,
    input  wire logic [PHYS_REG_BITS-1:0]             free_pd,
    input  wire logic                                 fl_empty,
    input  wire logic [PHYS_REG_BITS-1:0]             ps1,
    input  wire logic [PHYS_REG_BITS-1:0]             ps2,
    input  wire logic [PHYS_REG_BITS-1:0]             old_pd,
    input  wire logic                                 ps1_ready,
    input  wire logic                                 ps2_ready,
    output logic                                      dequeue,
    output logic                                      alloc,
    output logic      [rename_pkg::arch_reg_bits-1:0] rs1,
    output logic      [rename_pkg::arch_reg_bits-1:0] rs2,
    output logic      [rename_pkg::arch_reg_bits-1:0] rd,
    output logic                                      rename_we,
    output logic      [PHYS_REG_BITS-1:0]             rename_pd,
    output logic                                      disp_valid,
    output rename_pkg::rs_sel_e                       disp_rs_sel,
    output logic      [31:0]                          disp_inst,
    output logic      [rename_pkg::arch_reg_bits-1:0] disp_rd,
    output logic      [PHYS_REG_BITS-1:0]             disp_pd,
    output logic      [PHYS_REG_BITS-1:0]             disp_old_pd,
    output logic      [PHYS_REG_BITS-1:0]             disp_ps1,
    output logic      [PHYS_REG_BITS-1:0]             disp_ps2,
    output logic                                      disp_ps1_ready,
    output logic                                      disp_ps2_ready,
    output logic      [PHYS_REG_BITS-1:0]             disp_rob_tag,
    output logic                                      disp_writes_rd
);

    rv32i_pkg::rv32_inst_u inst_u;
    rename_pkg::rs_sel_e   rs_sel;
    logic                  is_muldiv;
    logic                  writes_rd;
    logic                  station_full;

    assign inst_u = inst;

    // sources and funct7 come from the R view, rd and opcode from the I view
    assign rs1 = inst_u.r_view.rs1;
    assign rs2 = inst_u.r_view.rs2;
    assign rd  = inst_u.i_view.rd;

    assign is_muldiv = (inst_u.i_view.opcode == rv32i_pkg::op_reg)
                    && (inst_u.r_view.funct7 == rv32i_pkg::muldiv_funct7);

    // funct3 msb splits mul* from div/rem
    always_comb begin
        rs_sel = rename_pkg::rs_alu;
        if (is_muldiv) begin
            if (inst_u.r_view.funct3 inside {rv32i_pkg::funct3_mul,
                                             rv32i_pkg::funct3_mulh,
                                             rv32i_pkg::funct3_mulhsu,
                                             rv32i_pkg::funct3_mulhu}) begin
                rs_sel = rename_pkg::rs_mul;
            end else begin
                rs_sel = rename_pkg::rs_div;
            end
        end
    end

    always_comb begin
        case (rs_sel)
            rename_pkg::rs_mul: station_full = rs_full_mul;
            rename_pkg::rs_div: station_full = rs_full_div;
            default:            station_full = rs_full_alu;
        endcase
    end

    // stores and branches have no rd field, x0 is discarded
    assign writes_rd = (inst_u.i_view.opcode != rv32i_pkg::op_store)
                    && (inst_u.i_view.opcode != rv32i_pkg::op_br)
                    && (inst_u.i_view.rd != '0);

    assign dequeue   = !iq_empty && !rob_full && !station_full && (!writes_rd || !fl_empty);
    assign alloc     = dequeue && writes_rd;
    assign rename_we = alloc;
    assign rename_pd = free_pd;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            disp_valid <= 1'b0;
        end else begin
            disp_valid <= dequeue;  // one-cycle strobe, no back-pressure
        end
    end

    // dispatch record, meaningful only with disp_valid
    always_ff @(posedge clk) begin
        if (dequeue) begin
            disp_rs_sel    <= rs_sel;
            disp_inst      <= inst;
            disp_rd        <= rd;
            disp_pd        <= writes_rd ? free_pd : '0;
            disp_old_pd    <= old_pd;
            disp_ps1       <= ps1;
            disp_ps2       <= ps2;
            disp_ps1_ready <= ps1_ready;
            disp_ps2_ready <= ps2_ready;
            disp_rob_tag   <= rob_tag;
            disp_writes_rd <= writes_rd;
        end
    end

    // p0 stays with x0, so the free list never hands it out
    a_no_alloc_p0: assert property (@(posedge clk) disable iff (!arst_n)
        alloc |-> free_pd != '0);

endmodule

`default_nettype wire

// ==== verilog/rename_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module rename_top #(
    parameter int PHYS_REG_BITS = 6   // more than 32 physical registers
) (
    input  wire logic                                 clk,
    input  wire logic                                 arst_n,
    input  wire logic [31:0]                          inst,
    input  wire logic                                 iq_empty,
    input  wire logic                                 rob_full,
    input  wire logic [PHYS_REG_BITS-1:0]             rob_tag,
    input  wire logic                                 rs_full_alu,
    input  wire logic                                 rs_full_mul,
    input  wire logic                                 rs_full_div,
    input  wire logic                                 retire_valid,
    input  wire logic [PHYS_REG_BITS-1:0]             retire_pd,
    input  wire logic                                 wb_valid,
    input  wire logic [PHYS_REG_BITS-1:0]             wb_pd,
    output logic                                      dequeue,
    output logic                                      disp_valid,
    output rename_pkg::rs_sel_e                       disp_rs_sel,
    output logic      [31:0]                          disp_inst,
    output logic      [rename_pkg::arch_reg_bits-1:0] disp_rd,
    output logic      [PHYS_REG_BITS-1:0]             disp_pd,
    output logic      [PHYS_REG_BITS-1:0]             disp_old_pd,
    output logic      [PHYS_REG_BITS-1:0]             disp_ps1,
    output logic      [PHYS_REG_BITS-1:0]             disp_ps2,
    output logic                                      disp_ps1_ready,
    output logic                                      disp_ps2_ready,
    output logic      [PHYS_REG_BITS-1:0]             disp_rob_tag,
    output logic                                      disp_writes_rd
);

    // rename <-> RAT
    logic [rename_pkg::arch_reg_bits-1:0] rs1;
    logic [rename_pkg::arch_reg_bits-1:0] rs2;
    logic [rename_pkg::arch_reg_bits-1:0] rd;
    logic                                 rename_we;
    logic [PHYS_REG_BITS-1:0]             rename_pd;
    logic [PHYS_REG_BITS-1:0]             ps1;
    logic [PHYS_REG_BITS-1:0]             ps2;
    logic [PHYS_REG_BITS-1:0]             old_pd;
    logic                                 ps1_ready;
    logic                                 ps2_ready;

    // rename <-> free list
    logic                                 alloc;
    logic [PHYS_REG_BITS-1:0]             free_pd;
    logic                                 fl_empty;

    free_list #(.PHYS_REG_BITS(PHYS_REG_BITS)) u_free_list (
        .clk, .arst_n, .alloc, .retire_valid, .retire_pd, .free_pd, .fl_empty
    );

    rat #(.PHYS_REG_BITS(PHYS_REG_BITS)) u_rat (
        .clk, .arst_n, .rs1, .rs2, .rd, .rename_we, .rename_pd, .wb_valid, .wb_pd,
        .ps1, .ps2, .old_pd, .ps1_ready, .ps2_ready
    );

    rename_dispatch #(.PHYS_REG_BITS(PHYS_REG_BITS)) u_rename_dispatch (
        .clk, .arst_n, .inst, .iq_empty, .rob_full, .rs_full_alu, .rs_full_mul, .rs_full_div,
        .rob_tag, .free_pd, .fl_empty, .ps1, .ps2, .old_pd, .ps1_ready, .ps2_ready,
        .dequeue, .alloc, .rs1, .rs2, .rd, .rename_we, .rename_pd,
        .disp_valid, .disp_rs_sel, .disp_inst, .disp_rd, .disp_pd, .disp_old_pd,
        .disp_ps1, .disp_ps2, .disp_ps1_ready, .disp_ps2_ready, .disp_rob_tag,
        .disp_writes_rd
    );

endmodule

`default_nettype wire

// ==== dv/rename_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module rename_checker #(
    parameter int PHYS_REG_BITS = 6
) (
    input  wire logic                                 clk,
    input  wire logic                                 arst_n,
    input  wire logic [31:0]                          inst,
    input  wire logic                                 iq_empty,
    input  wire logic                                 rob_full,
    input  wire logic [PHYS_REG_BITS-1:0]             rob_tag,
    input  wire logic                                 rs_full_alu,
    input  wire logic                                 rs_full_mul,
    input  wire logic                                 rs_full_div,
    input  wire logic                                 retire_valid,
    input  wire logic [PHYS_REG_BITS-1:0]             retire_pd,
    input  wire logic                                 wb_valid,
    input  wire logic [PHYS_REG_BITS-1:0]             wb_pd,
    input  wire logic                                 dequeue,
    input  wire logic                                 disp_valid,
    input  wire logic [1:0]                           disp_rs_sel,
    input  wire logic [31:0]                          disp_inst,
    input  wire logic [rename_pkg::arch_reg_bits-1:0] disp_rd,
    input  wire logic [PHYS_REG_BITS-1:0]             disp_pd,
    input  wire logic [PHYS_REG_BITS-1:0]             disp_old_pd,
    input  wire logic [PHYS_REG_BITS-1:0]             disp_ps1,
    input  wire logic [PHYS_REG_BITS-1:0]             disp_ps2,
    input  wire logic                                 disp_ps1_ready,
    input  wire logic                                 disp_ps2_ready,
    input  wire logic [PHYS_REG_BITS-1:0]             disp_rob_tag,
    input  wire logic                                 disp_writes_rd,
    output int                                        errors,
    output int                                        checks
);

    localparam int depth = 1 << PHYS_REG_BITS;

    logic [PHYS_REG_BITS-1:0] map_m [rename_pkg::arch_regs];
    logic                     ready_m [depth];
    logic [PHYS_REG_BITS-1:0] free_q [$];   // head at index 0

    // record that should show up one edge later
    logic                     exp_valid;
    logic [1:0]               exp_sel;
    logic [31:0]              exp_inst;
    logic [PHYS_REG_BITS-1:0] exp_pd;
    logic [PHYS_REG_BITS-1:0] exp_old;
    logic [PHYS_REG_BITS-1:0] exp_ps1;
    logic [PHYS_REG_BITS-1:0] exp_ps2;
    logic                     exp_rdy1;
    logic                     exp_rdy2;
    logic [PHYS_REG_BITS-1:0] exp_tag;
    logic                     exp_writes;

    task automatic reset_model();
        for (int i = 0; i < rename_pkg::arch_regs; i++) begin
            map_m[i] = PHYS_REG_BITS'(i);
        end
        for (int i = 0; i < depth; i++) begin
            ready_m[i] = 1'b1;
        end
        free_q.delete();
        for (int i = rename_pkg::arch_regs; i < depth; i++) begin
            free_q.push_back(PHYS_REG_BITS'(i));  // ascending order
        end
        exp_valid = 1'b0;
        errors    = 0;
        checks    = 0;
    endtask

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error at %0t ns: %s = %0h, expected %0h", $time, name, got, exp);
        end
    endtask

    // M-extension encodings go to mul or div, the rest to the ALU
    function automatic logic [1:0] station(input logic [31:0] w);
        if (w[6:0] != rv32i_pkg::op_reg || w[31:25] != rv32i_pkg::muldiv_funct7) begin
            return rename_pkg::rs_alu;
        end
        case (w[14:12])
            rv32i_pkg::funct3_mul, rv32i_pkg::funct3_mulh,
            rv32i_pkg::funct3_mulhsu, rv32i_pkg::funct3_mulhu: return rename_pkg::rs_mul;
            default: return rename_pkg::rs_div;
        endcase
    endfunction

    always @(posedge clk) begin
        logic [4:0] r1;
        logic [4:0] r2;
        logic [4:0] rd;
        logic [1:0] sel;
        logic       full;
        logic       writes;
        if (!arst_n) begin
            reset_model();
        end else begin
            compare("disp_valid", 32'(disp_valid), 32'(exp_valid));
            if (exp_valid) begin
                compare("disp_rs_sel", 32'(disp_rs_sel), 32'(exp_sel));
                compare("disp_inst", disp_inst, exp_inst);
                compare("disp_rd", 32'(disp_rd), 32'(exp_inst[11:7]));
                compare("disp_pd", 32'(disp_pd), 32'(exp_pd));
                compare("disp_old_pd", 32'(disp_old_pd), 32'(exp_old));
                compare("disp_ps1", 32'(disp_ps1), 32'(exp_ps1));
                compare("disp_ps2", 32'(disp_ps2), 32'(exp_ps2));
                compare("disp_ps1_ready", 32'(disp_ps1_ready), 32'(exp_rdy1));
                compare("disp_ps2_ready", 32'(disp_ps2_ready), 32'(exp_rdy2));
                compare("disp_rob_tag", 32'(disp_rob_tag), 32'(exp_tag));
                compare("disp_writes_rd", 32'(disp_writes_rd), 32'(exp_writes));
            end
            r1  = inst[19:15];
            r2  = inst[24:20];
            rd  = inst[11:7];
            sel = station(inst);
            full = (sel == rename_pkg::rs_mul) ? rs_full_mul
                 : (sel == rename_pkg::rs_div) ? rs_full_div : rs_full_alu;
            writes = (inst[6:0] != rv32i_pkg::op_store) && (inst[6:0] != rv32i_pkg::op_br)
                  && (rd != '0);
            exp_valid = !iq_empty && !rob_full && !full && (!writes || free_q.size() > 0);
            compare("dequeue", 32'(dequeue), 32'(exp_valid));
            if (exp_valid) begin
                exp_sel    = sel;
                exp_inst   = inst;
                exp_pd     = writes ? free_q[0] : '0;
                exp_old    = map_m[rd];
                exp_ps1    = (r1 == '0) ? '0 : map_m[r1];
                exp_ps2    = (r2 == '0) ? '0 : map_m[r2];
                exp_rdy1   = (r1 == '0) || ready_m[exp_ps1];
                exp_rdy2   = (r2 == '0) || ready_m[exp_ps2];
                exp_tag    = rob_tag;
                exp_writes = writes;
            end
            if (wb_valid) begin
                ready_m[wb_pd] = 1'b1;
            end
            if (exp_valid && writes) begin
                map_m[rd]          = free_q[0];
                ready_m[free_q[0]] = 1'b0;  // rename beats a writeback in the same cycle
                void'(free_q.pop_front());
            end
            if (retire_valid) begin
                free_q.push_back(retire_pd);
            end
        end
    end

endmodule

`default_nettype wire

// ==== dv/rename_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module rename_tb;

    localparam int phys_reg_bits = 6;

    typedef struct packed {
        logic [31:0]              inst;
        logic [4:0]               hold;   // iq_empty, rob_full, alu, mul, div full
        logic                     retire_valid;
        logic [phys_reg_bits-1:0] retire_pd;
        logic                     wb_valid;
        logic [phys_reg_bits-1:0] wb_pd;
    } row_t;

    logic                                 clk;
    logic                                 arst_n;
    logic [31:0]                          inst;
    logic                                 iq_empty;
    logic                                 rob_full;
    logic [phys_reg_bits-1:0]             rob_tag;
    logic                                 rs_full_alu;
    logic                                 rs_full_mul;
    logic                                 rs_full_div;
    logic                                 retire_valid;
    logic [phys_reg_bits-1:0]             retire_pd;
    logic                                 wb_valid;
    logic [phys_reg_bits-1:0]             wb_pd;
    logic                                 dequeue;
    logic                                 disp_valid;
    rename_pkg::rs_sel_e                  disp_rs_sel;
    logic [31:0]                          disp_inst;
    logic [rename_pkg::arch_reg_bits-1:0] disp_rd;
    logic [phys_reg_bits-1:0]             disp_pd;
    logic [phys_reg_bits-1:0]             disp_old_pd;
    logic [phys_reg_bits-1:0]             disp_ps1;
    logic [phys_reg_bits-1:0]             disp_ps2;
    logic                                 disp_ps1_ready;
    logic                                 disp_ps2_ready;
    logic [phys_reg_bits-1:0]             disp_rob_tag;
    logic                                 disp_writes_rd;
    int                                   errors;
    int                                   checks;

    row_t        rows [$];
    logic [31:0] seed   = 32'h522d6a39;
    int          cycles = 0;
    int          limit  = 0;

    rename_top #(.PHYS_REG_BITS(phys_reg_bits)) u_rename_top (.*);

    rename_checker #(.PHYS_REG_BITS(phys_reg_bits)) u_rename_checker (.*);

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles > limit) begin
            $display("timeout: test did not finish within %0d cycles", limit);
            $display("Checks failed");
            $finish;
        end
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [31:0] encode(input logic [6:0] f7, input int rs2, input int rs1,
                                           input logic [2:0] f3, input int rd,
                                           input logic [6:0] op);
        return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), op};
    endfunction

    task automatic add_row(input logic [31:0] w, input logic [4:0] hold = '0,
                           input logic rv = 1'b0, input int rpd = 0,
                           input logic wv = 1'b0, input int wpd = 0);
        rows.push_back({w, hold, rv, phys_reg_bits'(rpd), wv, phys_reg_bits'(wpd)});
    endtask

    task automatic build_table();
        logic [6:0]  ops [8];
        logic [31:0] w;
        ops = '{rv32i_pkg::op_reg, rv32i_pkg::op_reg, rv32i_pkg::op_imm, rv32i_pkg::op_load,
                rv32i_pkg::op_store, rv32i_pkg::op_br, rv32i_pkg::op_lui, rv32i_pkg::op_jal};
        add_row(encode(7'd0, 1, 0, 3'd0, 5, rv32i_pkg::op_imm));    // x5 -> p32
        add_row(encode(7'd0, 1, 5, 3'd0, 5, rv32i_pkg::op_imm));    // x5 -> p33, reads p32
        add_row(encode(7'd0, 5, 5, 3'd0, 6, rv32i_pkg::op_reg));
        add_row(encode(rv32i_pkg::muldiv_funct7, 5, 6, rv32i_pkg::funct3_mul, 7,
                       rv32i_pkg::op_reg));
        add_row(encode(rv32i_pkg::muldiv_funct7, 2, 1, rv32i_pkg::funct3_div, 8,
                       rv32i_pkg::op_reg));
        // full flags hold back only their own class
        w = encode(rv32i_pkg::muldiv_funct7, 2, 1, rv32i_pkg::funct3_mulhu, 9, rv32i_pkg::op_reg);
        add_row(w, 5'b00010);
        add_row(w, 5'b00100);
        add_row(encode(rv32i_pkg::muldiv_funct7, 2, 1, rv32i_pkg::funct3_remu, 10,
                       rv32i_pkg::op_reg), 5'b00010);
        add_row(encode(7'd0, 2, 1, 3'd0, 11, rv32i_pkg::op_reg), 5'b00001);
        add_row(encode(7'd0, 2, 1, 3'd0, 12, rv32i_pkg::op_reg), 5'b10000);
        add_row(encode(7'd0, 2, 1, 3'd0, 12, rv32i_pkg::op_reg), 5'b01000);
        // no destination: store, branch, x0
        add_row(encode(7'd0, 5, 6, 3'b010, 4, rv32i_pkg::op_store));
        add_row(encode(7'd0, 6, 5, 3'd0, 8, rv32i_pkg::op_br));
        add_row(encode(7'd0, 6, 5, 3'd0, 0, rv32i_pkg::op_reg));
        add_row(32'h0, 5'b10000, 1'b0, 0, 1'b1, 33);    // writeback of p33 only
        add_row(encode(7'd0, 5, 5, 3'd0, 13, rv32i_pkg::op_reg));
        for (int i = 0; i < 23; i++) begin
            add_row(encode(7'd0, 1, 14 + i % 18, 3'd0, 14 + i % 18, rv32i_pkg::op_imm));
        end
        // free list is now empty, p32 comes back through retire
        add_row(encode(7'd0, 6, 6, 3'd0, 5, rv32i_pkg::op_reg), 5'b0, 1'b1, 32);
        add_row(encode(7'd0, 6, 6, 3'd0, 5, rv32i_pkg::op_reg), 5'b0, 1'b0, 0, 1'b1, 32);
        add_row(encode(7'd0, 5, 5, 3'b010, 0, rv32i_pkg::op_store));
        for (int i = 0; i < 24; i++) begin
            seed   = lcg_next(seed);
            w      = seed;
            w[6:0] = ops[seed[30:28]];
            if (seed[27]) begin
                w[31:25] = rv32i_pkg::muldiv_funct7;
            end
            seed = lcg_next(seed);
            add_row(w, {seed[31:29] == 3'd0, seed[28:26] == 3'd0, seed[25:23] == 3'd0,
                        seed[22:20] == 3'd0, seed[19:17] == 3'd0},
                    seed[16], 32 + int'(seed[15:11]), seed[10], int'(seed[9:4]));
        end
    endtask

    task automatic apply_row(input row_t r, input int idx);
        inst         = r.inst;
        {iq_empty, rob_full, rs_full_alu, rs_full_mul, rs_full_div} = r.hold;
        retire_valid = r.retire_valid;
        retire_pd    = r.retire_pd;
        wb_valid     = r.wb_valid;
        wb_pd        = r.wb_pd;
        rob_tag      = phys_reg_bits'(idx);
    endtask

    initial begin
        clk          = 1'b0;
        arst_n       = 1'b0;
        inst         = '0;
        iq_empty     = 1'b1;
        rob_full     = 1'b0;
        rob_tag      = '0;
        rs_full_alu  = 1'b0;
        rs_full_mul  = 1'b0;
        rs_full_div  = 1'b0;
        retire_valid = 1'b0;
        retire_pd    = '0;
        wb_valid     = 1'b0;
        wb_pd        = '0;
        build_table();
        limit = rows.size() + 20;
        repeat (3) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        foreach (rows[i]) begin
            @(negedge clk);
            apply_row(rows[i], i);
        end
        @(negedge clk);
        iq_empty     = 1'b1;   // drain the last dispatch
        retire_valid = 1'b0;
        wb_valid     = 1'b0;
        repeat (2) @(negedge clk);
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0 && checks > 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== build.f ====
verilog/rv32i_pkg.sv
verilog/rename_pkg.sv
verilog/free_list.sv
verilog/rat.sv
verilog/rename_dispatch.sv
verilog/rename_top.sv
dv/rename_checker.sv
dv/rename_tb.sv

// ==== Makefile ====
TOP := rename_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f build.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f build.f
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "All checks passed"

clean:
	rm -rf obj_dir
